// ==== csr_subsys.f ====
logic/csr_pkg.sv
logic/csr_access.sv
logic/csr_regs.sv
logic/csr_timer.sv
logic/csr_irq.sv
logic/csr_subsys.sv
verif/tb_csr_subsys.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the CSR unit testbench with Verilator, exit status 1 on failure
verilator --binary --timing -Wno-fatal -f csr_subsys.f --top-module tb_csr_subsys \
    && ./obj_dir/Vtb_csr_subsys | tee /dev/stderr | grep -q "PASS: all tests" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== verif/tb_csr_subsys.sv ====
// Directed testbench for the CSR unit and top of the simulation built from the file list
`timescale 1ns/1ps

module tb_csr_subsys import csr_pkg::*; ();

    // DUT inputs
    logic    clk_i;
    logic    rst_i;
    logic    fu_ena_i;
    funct3_t funct_i;
    xlen_t   src1_i;
    xlen_t   src2_i;
    logic    rd_zero_i;
    logic    rs1_zero_i;
    xlen_t   trap_pc_i;
    xlen_t   trap_adr_i;
    logic    ex_i;
    cause_t  ex_cause_i;
    logic    mret_i;
    logic    msip_i;
    logic    meip_i;

    // DUT outputs
    logic    fu_rdy_o;
    xlen_t   fu_res_o;
    logic    fu_err_o;
    xlen_t   trap_vec_o;
    logic    intr_o;

    integer      errors;
    integer      seed;
    int unsigned cycle_cnt = 0;   // Edges since time 0
    xlen_t       mscratch_model;  // Expected mscratch contents

    csr_subsys u_csr_subsys (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .fu_ena_i   (fu_ena_i),
        .funct_i    (funct_i),
        .src1_i     (src1_i),
        .src2_i     (src2_i),
        .rd_zero_i  (rd_zero_i),
        .rs1_zero_i (rs1_zero_i),
        .fu_rdy_o   (fu_rdy_o),
        .fu_res_o   (fu_res_o),
        .fu_err_o   (fu_err_o),
        .trap_pc_i  (trap_pc_i),
        .trap_adr_i (trap_adr_i),
        .ex_i       (ex_i),
        .ex_cause_i (ex_cause_i),
        .mret_i     (mret_i),
        .trap_vec_o (trap_vec_o),
        .msip_i     (msip_i),
        .meip_i     (meip_i),
        .intr_o     (intr_o)
    );

    always #50 clk_i = ~clk_i;  // 100 ns period

    always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

    // Compare and count
    task automatic check(input string name, input xlen_t exp, input xlen_t act);
        if (exp !== act) begin
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    // Advance one clock and return 1 ns after the edge
    task automatic wait_cycle();
        @(posedge clk_i);
        #1;
    endtask

    // One access held for one cycle from 1 ns after an edge
    task automatic csr_op(input funct3_t funct, input csr_adr_t adr, input xlen_t src,
                          input logic rs1_zero, output xlen_t res, output logic err);
        fu_ena_i   = 1'b1;
        funct_i    = funct;
        src1_i     = src;
        src2_i     = {20'h0, adr};
        rs1_zero_i = rs1_zero;
        rd_zero_i  = 1'b0;
        #20;                          // Combinational answer settled
        check("fu_rdy_o during access", 32'h1, xlen_t'(fu_rdy_o));
        res = fu_res_o;
        err = fu_err_o;
        wait_cycle();                 // Write lands at this edge
        fu_ena_i = 1'b0;
    endtask

    // Plain read through CSRRS with rs1 = x0
    task automatic read_expect(input string name, input csr_adr_t adr, input xlen_t exp);
        xlen_t res;
        logic  err;
        csr_op(FUNCT3_CSR_RS, adr, '0, 1'b1, res, err);
        check(name, exp, res);
        check({name, " error flag"}, '0, xlen_t'(err));
    endtask

    // New CSR value from the write rules
    function automatic xlen_t merge_model(input funct3_t funct, input xlen_t old,
                                          input xlen_t src, input logic rs1_zero);
        case (funct)
            FUNCT3_CSR_RW, FUNCT3_CSR_RWI: return src;
            FUNCT3_CSR_RS, FUNCT3_CSR_RSI: return rs1_zero ? old : (old | src);
            FUNCT3_CSR_RC, FUNCT3_CSR_RCI: return rs1_zero ? old : (old & ~src);
            default: return old;      // Invalid code never writes
        endcase
    endfunction

    task automatic test_rw_set_clear();
        funct3_t ops [6];
        xlen_t   src;
        xlen_t   res;
        logic    err;
        logic    zero;
        ops = '{FUNCT3_CSR_RW, FUNCT3_CSR_RS, FUNCT3_CSR_RC,
                FUNCT3_CSR_RWI, FUNCT3_CSR_RSI, FUNCT3_CSR_RCI};
        for (int round = 0; round < 16; round++) begin
            for (int k = 0; k < 6; k++) begin
                src = $random(seed);
                if (ops[k][2]) src = src & 32'h1F;  // uimm is 5 bits
                zero = (src == '0);
                csr_op(ops[k], CSR_MSCRATCH, src, zero, res, err);
                check("rw_set_clear old value", mscratch_model, res);
                check("rw_set_clear error flag", '0, xlen_t'(err));
                mscratch_model = merge_model(ops[k], mscratch_model, src, zero);
            end
        end
        // Set and clear with rs1 = x0 only read
        csr_op(FUNCT3_CSR_RS, CSR_MSCRATCH, 32'hFFFF_FFFF, 1'b1, res, err);
        check("rs with x0 old value", mscratch_model, res);
        csr_op(FUNCT3_CSR_RC, CSR_MSCRATCH, 32'hFFFF_FFFF, 1'b1, res, err);
        check("rc with x0 old value", mscratch_model, res);
        read_expect("mscratch after x0 set and clear", CSR_MSCRATCH, mscratch_model);
    endtask

    task automatic test_errors();
        xlen_t res;
        logic  err;
        xlen_t src;
        // MPP = 3 in bits 12:11 with MIE and MPIE clear
        read_expect("reset mstatus", CSR_MSTATUS, 32'h0000_1800);
        src = $random(seed);
        csr_op(3'd0, CSR_MSCRATCH, src, 1'b0, res, err);      // Invalid funct
        check("funct 0 error flag", 32'h1, xlen_t'(err));
        check("funct 0 result", '0, res);
        csr_op(3'd4, CSR_MSCRATCH, src, 1'b0, res, err);
        check("funct 4 error flag", 32'h1, xlen_t'(err));
        check("funct 4 result", '0, res);
        read_expect("mscratch after invalid funct", CSR_MSCRATCH, mscratch_model);
        csr_op(FUNCT3_CSR_RW, 12'h7FF, src, 1'b0, res, err);  // Nothing mapped here
        check("unmapped error flag", 32'h1, xlen_t'(err));
        check("unmapped result", '0, res);
        csr_op(FUNCT3_CSR_RW, CSR_MISA, src, 1'b0, res, err);
        check("misa write error flag", '0, xlen_t'(err));
        check("misa write old value", MISA_VALUE, res);
        read_expect("misa after write", CSR_MISA, MISA_VALUE);
    endtask

    task automatic test_exception();
        xlen_t  tvec;
        xlen_t  pc;
        xlen_t  adr;
        cause_t cause;
        xlen_t  res;
        logic   err;
        tvec = $random(seed);
        tvec = tvec | 32'h3;          // Mode bits set that must not reach the vector
        csr_op(FUNCT3_CSR_RW, CSR_MTVEC, tvec, 1'b0, res, err);
        check("trap_vec from mtvec", tvec & ~32'h3, trap_vec_o);
        csr_op(FUNCT3_CSR_RW, CSR_MSTATUS, 32'h8, 1'b0, res, err);  // MIE on while mie is 0
        check("mstatus before exception", 32'h0000_1800, res);
        pc    = $random(seed);
        adr   = $random(seed);
        cause = cause_t'($random(seed));
        trap_pc_i  = pc;
        trap_adr_i = adr;
        ex_cause_i = cause;
        ex_i       = 1'b1;
        wait_cycle();                 // Trap entry
        ex_i       = 1'b0;
        read_expect("exception mepc", CSR_MEPC, pc);
        read_expect("exception mtval", CSR_MTVAL, adr);
        read_expect("exception mcause", CSR_MCAUSE, {28'h0, cause});
        read_expect("exception mstatus stack", CSR_MSTATUS, 32'h0000_1880);
        mret_i = 1'b1;
        #20;
        check("trap_vec during mret", pc, trap_vec_o);
        wait_cycle();
        mret_i = 1'b0;
        #20;                          // Vector mux follows mret_i
        check("trap_vec after mret", tvec & ~32'h3, trap_vec_o);
        read_expect("mstatus after mret", CSR_MSTATUS, 32'h0000_1888);  // MIE back
    endtask

    task automatic test_interrupt_priority();
        xlen_t res;
        logic  err;
        xlen_t pc;
        csr_op(FUNCT3_CSR_RW, CSR_MIE, 32'h0000_0888, 1'b0, res, err);  // MEI, MTI, MSI
        read_expect("mie enables", CSR_MIE, 32'h0000_0888);
        csr_op(FUNCT3_CSR_RS, CSR_MSTATUS, 32'h8, 1'b0, res, err);
        pc        = $random(seed);
        trap_pc_i = pc;
        meip_i    = 1'b1;
        msip_i    = 1'b1;
        #20;
        check("intr_o with both lines", 32'h1, xlen_t'(intr_o));
        wait_cycle();                 // Interrupt taken here
        check("intr_o after entry", '0, xlen_t'(intr_o));
        read_expect("mip both lines", CSR_MIP, 32'h0000_0808);
        read_expect("mcause external first", CSR_MCAUSE, 32'h8000_000B);
        read_expect("mepc on interrupt", CSR_MEPC, pc);
        read_expect("mtval on interrupt", CSR_MTVAL, '0);
        meip_i = 1'b0;
        mret_i = 1'b1;
        wait_cycle();
        mret_i = 1'b0;
        check("intr_o software pending", 32'h1, xlen_t'(intr_o));  // MIE restored
        wait_cycle();
        check("intr_o after second entry", '0, xlen_t'(intr_o));
        read_expect("mcause software", CSR_MCAUSE, 32'h8000_0003);
        read_expect("mip software only", CSR_MIP, 32'h0000_0008);
        msip_i = 1'b0;
        mret_i = 1'b1;
        wait_cycle();
        mret_i = 1'b0;
        check("intr_o with lines low", '0, xlen_t'(intr_o));
    endtask

    task automatic test_timer();
        xlen_t       res;
        logic        err;
        xlen_t       first;
        xlen_t       second;
        int unsigned t0;
        csr_op(FUNCT3_CSR_RW, CSR_MCYCLE, '0, 1'b1, res, err);  // RW with x0 still writes
        csr_op(FUNCT3_CSR_RW, CSR_MTIMECMP, 32'd20, 1'b0, res, err);
        t0 = cycle_cnt;
        csr_op(FUNCT3_CSR_RS, CSR_MIP, '0, 1'b1, res, err);
        check("mip timer bit before compare", '0, xlen_t'(res[MTI_BIT]));
        csr_op(FUNCT3_CSR_RS, CSR_MCYCLE, '0, 1'b1, first, err);
        repeat (3) read_expect("mtimecmp readback", CSR_MTIMECMP, 32'd20);
        csr_op(FUNCT3_CSR_RS, CSR_MCYCLE, '0, 1'b1, second, err);
        check("mcycle four accesses apart", first + 32'd4, second);
        while ((intr_o !== 1'b1) && ((cycle_cnt - t0) < 25)) wait_cycle();
        if (intr_o !== 1'b1) begin
            $display("ERROR: intr_o did not rise within 25 cycles of the mtimecmp write");
            errors++;
        end else begin
            read_expect("mip timer pending", CSR_MIP, 32'h0000_0080);
            read_expect("mcause timer", CSR_MCAUSE, 32'h8000_0007);
        end
    endtask

    initial begin
        clk_i      = 1'b0;
        rst_i      = 1'b1;
        fu_ena_i   = 1'b0;
        funct_i    = '0;
        src1_i     = '0;
        src2_i     = '0;
        rd_zero_i  = 1'b0;
        rs1_zero_i = 1'b0;
        trap_pc_i  = '0;
        trap_adr_i = '0;
        ex_i       = 1'b0;
        ex_cause_i = '0;
        mret_i     = 1'b0;
        msip_i     = 1'b0;
        meip_i     = 1'b0;
        errors         = 0;
        seed           = 46;
        mscratch_model = '0;
        repeat (2) @(posedge clk_i);  // Reset for two cycles
        #1;
        rst_i = 1'b0;
        check("fu_rdy_o after reset", '0, xlen_t'(fu_rdy_o));
        check("fu_err_o after reset", '0, xlen_t'(fu_err_o));
        check("intr_o after reset", '0, xlen_t'(intr_o));
        test_rw_set_clear();
        test_errors();
        test_exception();
        test_interrupt_priority();
        test_timer();
        $display("Tests done with %0d errors", errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Tests need under 300 cycles
    initial begin
        repeat (3000) @(posedge clk_i);
        $display("ERROR: watchdog timeout, tests still running after 3000 cycles");
        errors++;
        $display("Tests done with %0d errors", errors);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== logic/csr_subsys.sv ====
// Top level of the machine-mode CSR unit, connects access block, bank, timer and arbiter to the core
`timescale 1ns/1ps

module csr_subsys import csr_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_i,

    // Function unit
    input  logic    fu_ena_i,
    input  funct3_t funct_i,
    input  xlen_t   src1_i,
    input  xlen_t   src2_i,
    input  logic    rd_zero_i,    // No CSR has read side effects, kept for the core interface
    input  logic    rs1_zero_i,
    output logic    fu_rdy_o,
    output xlen_t   fu_res_o,
    output logic    fu_err_o,

    // Traps
    input  xlen_t   trap_pc_i,
    input  xlen_t   trap_adr_i,
    input  logic    ex_i,
    input  cause_t  ex_cause_i,
    input  logic    mret_i,
    output xlen_t   trap_vec_o,

    // Interrupt lines
    input  logic    msip_i,
    input  logic    meip_i,
    output logic    intr_o
);

    // CSR bus
    csr_adr_t csr_adr;
    logic     csr_we;
    xlen_t    csr_wdat;
    xlen_t    regs_rdat, tmr_rdat;
    logic     regs_hit, tmr_hit;

    // Interrupt path
    logic     mtip;
    logic     intr, intr_ena;
    cause_t   intr_cause;
    ivec_t    intr_pend, intr_ena_vec;

    csr_access u_access (
        .fu_ena_i (fu_ena_i),   .funct_i    (funct_i),    .src1_i     (src1_i),
        .src2_i   (src2_i),     .rs1_zero_i (rs1_zero_i),
        .fu_rdy_o (fu_rdy_o),   .fu_res_o   (fu_res_o),   .fu_err_o   (fu_err_o),
        .csr_adr_o(csr_adr),    .csr_we_o   (csr_we),     .csr_wdat_o (csr_wdat),
        .regs_rdat_i (regs_rdat), .regs_hit_i (regs_hit),
        .tmr_rdat_i  (tmr_rdat),  .tmr_hit_i  (tmr_hit)
    );

    csr_regs u_regs (
        .clk_i (clk_i), .rst_i (rst_i),
        .csr_adr_i (csr_adr), .csr_we_i (csr_we), .csr_wdat_i (csr_wdat),
        .csr_rdat_o (regs_rdat), .csr_hit_o (regs_hit),
        .trap_pc_i (trap_pc_i), .trap_adr_i (trap_adr_i),
        .ex_i (ex_i), .ex_cause_i (ex_cause_i), .mret_i (mret_i), .trap_vec_o (trap_vec_o),
        .intr_i (intr), .intr_cause_i (intr_cause), .intr_pend_i (intr_pend),
        .intr_ena_o (intr_ena), .intr_ena_vec_o (intr_ena_vec)
    );

    csr_timer u_timer (
        .clk_i (clk_i), .rst_i (rst_i),
        .csr_adr_i (csr_adr), .csr_we_i (csr_we), .csr_wdat_i (csr_wdat),
        .csr_rdat_o (tmr_rdat), .csr_hit_o (tmr_hit), .mtip_o (mtip)
    );

    csr_irq u_irq (
        .msip_i (msip_i), .meip_i (meip_i), .mtip_i (mtip),
        .intr_ena_i (intr_ena), .intr_ena_vec_i (intr_ena_vec),
        .intr_pend_o (intr_pend), .intr_o (intr), .intr_cause_o (intr_cause)
    );

    assign intr_o = intr;  // Same level the bank samples

endmodule

// ==== logic/csr_irq.sv ====
// Interrupt arbiter, masks pending lines with mie and MIE and picks the cause by fixed priority
`timescale 1ns/1ps

module csr_irq import csr_pkg::*; (
    input  logic   msip_i,          // Software interrupt level
    input  logic   meip_i,          // External interrupt level
    input  logic   mtip_i,          // Timer compare hit
    input  logic   intr_ena_i,      // mstatus.MIE
    input  ivec_t  intr_ena_vec_i,  // mie
    output ivec_t  intr_pend_o,     // mip layout
    output logic   intr_o,          // Take an interrupt
    output cause_t intr_cause_o
);

    ivec_t active;  // Pending and enabled in mie

    // Place the lines at their mip positions
    always_comb begin
        intr_pend_o          = '0;
        intr_pend_o[MSI_BIT] = msip_i;
        intr_pend_o[MTI_BIT] = mtip_i;
        intr_pend_o[MEI_BIT] = meip_i;
    end

    assign active = intr_pend_o & intr_ena_vec_i;
    assign intr_o = intr_ena_i & (|active);   // Global gate last

    // External, then software, then timer
    always_comb begin
        if (active[MEI_BIT]) begin
            intr_cause_o = cause_t'(MEI_BIT);
        end else if (active[MSI_BIT]) begin
            intr_cause_o = cause_t'(MSI_BIT);
        end else if (active[MTI_BIT]) begin
            intr_cause_o = cause_t'(MTI_BIT);
        end else begin
            intr_cause_o = '0;   // Unused when intr_o is low
        end
    end

endmodule

// ==== logic/csr_timer.sv ====
// Free-running mcycle counter and mtimecmp compare, CSR-accessible, drives the timer pending line
`timescale 1ns/1ps

module csr_timer import csr_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_i,
    input  csr_adr_t csr_adr_i,
    input  logic     csr_we_i,
    input  xlen_t    csr_wdat_i,
    output xlen_t    csr_rdat_o,
    output logic     csr_hit_o,   // mcycle or mtimecmp addressed
    output logic     mtip_o       // Timer interrupt pending
);

    xlen_t mcycle_q;
    xlen_t mtimecmp_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mcycle_q   <= '0;
            mtimecmp_q <= '1;  // Far away, nothing pending
        end else begin
            if (csr_we_i && (csr_adr_i == CSR_MCYCLE)) mcycle_q <= csr_wdat_i;  // Load beats count
            else mcycle_q <= mcycle_q + 1'b1;
            if (csr_we_i && (csr_adr_i == CSR_MTIMECMP)) mtimecmp_q <= csr_wdat_i;
        end
    end

    // Read mux
    assign csr_hit_o  = (csr_adr_i == CSR_MCYCLE) || (csr_adr_i == CSR_MTIMECMP);
    assign csr_rdat_o = (csr_adr_i == CSR_MCYCLE)   ? mcycle_q   :
                        (csr_adr_i == CSR_MTIMECMP) ? mtimecmp_q : '0;

    // Unsigned compare, level stays high until mtimecmp moves
    assign mtip_o = (mcycle_q >= mtimecmp_q);

endmodule

// ==== logic/csr_regs.sv ====
// Machine-mode CSR bank with trap entry, mret and trap vector, driven by the access block and trap logic
`timescale 1ns/1ps

module csr_regs import csr_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_i,

    // CSR access
    input  csr_adr_t csr_adr_i,
    input  logic     csr_we_i,
    input  xlen_t    csr_wdat_i,
    output xlen_t    csr_rdat_o,
    output logic     csr_hit_o,       // Address belongs to this bank

    // Traps
    input  xlen_t    trap_pc_i,       // PC of the trapping instruction
    input  xlen_t    trap_adr_i,      // Faulting memory address
    input  logic     ex_i,            // Exception this cycle
    input  cause_t   ex_cause_i,
    input  logic     mret_i,          // Return from trap
    output xlen_t    trap_vec_o,      // Target PC for trap entry or return

    // Interrupts
    input  logic     intr_i,          // Enabled interrupt pending
    input  cause_t   intr_cause_i,
    input  ivec_t    intr_pend_i,     // Shown as mip
    output logic     intr_ena_o,      // mstatus.MIE
    output ivec_t    intr_ena_vec_o   // mie
);

    // Trap state
    logic  mstatus_mie;   // Global interrupt enable
    logic  mstatus_mpie;  // Enable before the last trap
    ivec_t mie_q;
    xlen_t mtvec_q;
    xlen_t mscratch_q;
    xlen_t mepc_q;
    xlen_t mcause_q;
    xlen_t mtval_q;

    xlen_t mstatus_rd;    // Assembled mstatus view

    // Only MIE, MPIE and MPP exist, MPP hardwired to machine mode
    always_comb begin
        mstatus_rd = '0;
        mstatus_rd[MSTATUS_MIE]      = mstatus_mie;
        mstatus_rd[MSTATUS_MPIE]     = mstatus_mpie;
        mstatus_rd[MSTATUS_MPP +: 2] = PRIV_M;
    end

    // Read decode and hit flag
    always_comb begin
        csr_rdat_o = '0;
        csr_hit_o  = 1'b1;
        case (csr_adr_i)
            CSR_MSTATUS:  csr_rdat_o = mstatus_rd;
            CSR_MISA:     csr_rdat_o = MISA_VALUE;   // Constant RV32I
            CSR_MIE:      csr_rdat_o = mie_q;
            CSR_MTVEC:    csr_rdat_o = mtvec_q;
            CSR_MSCRATCH: csr_rdat_o = mscratch_q;
            CSR_MEPC:     csr_rdat_o = mepc_q;
            CSR_MCAUSE:   csr_rdat_o = mcause_q;
            CSR_MTVAL:    csr_rdat_o = mtval_q;
            CSR_MIP:      csr_rdat_o = intr_pend_i;  // Live pending lines
            default: begin
                csr_hit_o = 1'b0;  // Timer or unmapped
            end
        endcase
    end

    // Register updates
    // Later assignments win, so trap events override a CSR write in the same cycle
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mie_q        <= '0;
            mtvec_q      <= '0;
            mscratch_q   <= '0;
            mepc_q       <= '0;
            mcause_q     <= '0;
            mtval_q      <= '0;
        end else begin
            if (csr_we_i) begin
                case (csr_adr_i)
                    CSR_MSTATUS: begin
                        mstatus_mie  <= csr_wdat_i[MSTATUS_MIE];
                        mstatus_mpie <= csr_wdat_i[MSTATUS_MPIE];
                    end
                    CSR_MIE:      mie_q      <= csr_wdat_i & MIE_MASK;  // Unimplemented bits stay 0
                    CSR_MTVEC:    mtvec_q    <= csr_wdat_i;
                    CSR_MSCRATCH: mscratch_q <= csr_wdat_i;
                    CSR_MEPC:     mepc_q     <= csr_wdat_i;
                    CSR_MCAUSE:   mcause_q   <= csr_wdat_i;
                    CSR_MTVAL:    mtval_q    <= csr_wdat_i;
                    default: ;  // misa and mip ignore writes
                endcase
            end

            // Trap sequencer, exception before interrupt before mret
            if (ex_i) begin
                mepc_q       <= trap_pc_i;
                mcause_q     <= {1'b0, {(XLEN-5){1'b0}}, ex_cause_i};
                mtval_q      <= trap_adr_i;
                mstatus_mpie <= mstatus_mie;   // Stack the enable
                mstatus_mie  <= 1'b0;
            end else if (intr_i) begin
                mepc_q       <= trap_pc_i;
                mcause_q     <= {1'b1, {(XLEN-5){1'b0}}, intr_cause_i};  // Interrupt flag set
                mtval_q      <= '0;
                mstatus_mpie <= mstatus_mie;
                mstatus_mie  <= 1'b0;          // Drops intr on the next cycle
            end else if (mret_i) begin
                mstatus_mie  <= mstatus_mpie;  // Pop the enable
                mstatus_mpie <= 1'b1;
            end
        end
    end

    // mret jumps back to mepc, everything else to the direct-mode base
    assign trap_vec_o = mret_i ? mepc_q : {mtvec_q[XLEN-1:2], 2'b00};

    // Enables to the interrupt arbiter
    assign intr_ena_o     = mstatus_mie;
    assign intr_ena_vec_o = mie_q;

endmodule

// ==== logic/csr_access.sv ====
// CSR instruction execution, merges the operand with the old value and drives the bank and timer
`timescale 1ns/1ps

module csr_access import csr_pkg::*; (
    // Function unit side
    input  logic     fu_ena_i,     // Instruction issued to this unit
    input  funct3_t  funct_i,      // CSR function
    input  xlen_t    src1_i,       // rs1 value or uimm
    input  xlen_t    src2_i,       // Low 12 bits hold the CSR address
    input  logic     rs1_zero_i,   // rs1 is x0 or uimm is 0
    output logic     fu_rdy_o,
    output xlen_t    fu_res_o,
    output logic     fu_err_o,

    // CSR bus to bank and timer
    output csr_adr_t csr_adr_o,
    output logic     csr_we_o,
    output xlen_t    csr_wdat_o,
    input  xlen_t    regs_rdat_i,
    input  logic     regs_hit_i,
    input  xlen_t    tmr_rdat_i,
    input  logic     tmr_hit_i
);

    logic  is_rw;      // Plain write
    logic  is_set;     // Bit set
    logic  is_clr;     // Bit clear
    logic  funct_ok;   // One of the six legal codes
    logic  hit;        // Some block owns the address
    logic  acc_ok;     // Legal access this cycle
    xlen_t old_dat;    // Value before the access
    xlen_t new_dat;    // Merged write value

    // funct3 decode, immediate forms share the register form's behavior
    assign is_rw  = (funct_i == FUNCT3_CSR_RW) || (funct_i == FUNCT3_CSR_RWI);
    assign is_set = (funct_i == FUNCT3_CSR_RS) || (funct_i == FUNCT3_CSR_RSI);
    assign is_clr = (funct_i == FUNCT3_CSR_RC) || (funct_i == FUNCT3_CSR_RCI);
    assign funct_ok = is_rw | is_set | is_clr;

    assign csr_adr_o = src2_i[11:0];  // Address decoded by both blocks in parallel

    // Old value from whichever block claims the address
    assign hit     = regs_hit_i | tmr_hit_i;
    assign old_dat = regs_hit_i ? regs_rdat_i :
                     tmr_hit_i  ? tmr_rdat_i  : '0;

    always_comb begin
        if (is_set) begin
            new_dat = old_dat | src1_i;   // CSRRS
        end else if (is_clr) begin
            new_dat = old_dat & ~src1_i;  // CSRRC
        end else begin
            new_dat = src1_i;             // CSRRW
        end
    end

    assign acc_ok = fu_ena_i & funct_ok & hit;

    // Always ready, result in the issue cycle
    assign fu_rdy_o = fu_ena_i;
    assign fu_err_o = fu_ena_i & ~(funct_ok & hit);    // Bad funct or unmapped address
    assign fu_res_o = acc_ok ? old_dat : '0;

    // Set and clear with x0 read only
    assign csr_we_o   = acc_ok & (is_rw | ~rs1_zero_i);
    assign csr_wdat_o = new_dat;

endmodule

// ==== logic/csr_pkg.sv ====
// Shared widths, types, function codes, CSR addresses and bit positions, imported by every CSR block
package csr_pkg;

    // Data width, fixed since the register layouts depend on it
    localparam int XLEN = 32;

    // Vector types
    typedef logic [XLEN-1:0] xlen_t;     // Operands, CSR data and PCs
    typedef logic [11:0]     csr_adr_t;  // CSR address field
    typedef logic [2:0]      funct3_t;   // CSR function code
    typedef logic [3:0]      cause_t;    // Exception or interrupt code
    typedef logic [XLEN-1:0] ivec_t;     // Interrupt vector in mie/mip layout

    // CSR function codes, register forms
    localparam funct3_t FUNCT3_CSR_RW  = 3'd1;
    localparam funct3_t FUNCT3_CSR_RS  = 3'd2;
    localparam funct3_t FUNCT3_CSR_RC  = 3'd3;

    // Immediate forms, src1 carries the zero-extended uimm
    localparam funct3_t FUNCT3_CSR_RWI = 3'd5;
    localparam funct3_t FUNCT3_CSR_RSI = 3'd6;
    localparam funct3_t FUNCT3_CSR_RCI = 3'd7;

    // Machine trap setup
    localparam csr_adr_t CSR_MSTATUS  = 12'h300;
    localparam csr_adr_t CSR_MISA     = 12'h301;
    localparam csr_adr_t CSR_MIE      = 12'h304;
    localparam csr_adr_t CSR_MTVEC    = 12'h305;

    // Machine trap handling
    localparam csr_adr_t CSR_MSCRATCH = 12'h340;
    localparam csr_adr_t CSR_MEPC     = 12'h341;
    localparam csr_adr_t CSR_MCAUSE   = 12'h342;
    localparam csr_adr_t CSR_MTVAL    = 12'h343;
    localparam csr_adr_t CSR_MIP      = 12'h344;

    // Timer
    localparam csr_adr_t CSR_MTIMECMP = 12'h7C0;  // Custom machine read/write space
    localparam csr_adr_t CSR_MCYCLE   = 12'hB00;

    // mstatus fields
    localparam int MSTATUS_MIE  = 3;
    localparam int MSTATUS_MPIE = 7;
    localparam int MSTATUS_MPP  = 11;             // Low bit of the two-bit MPP field
    localparam logic [1:0] PRIV_M = 2'b11;        // Machine mode encoding

    // Interrupt bits, also the interrupt cause codes
    localparam int MSI_BIT = 3;                   // Software
    localparam int MTI_BIT = 7;                   // Timer
    localparam int MEI_BIT = 11;                  // External

    // Only these mie bits exist
    localparam ivec_t MIE_MASK = ivec_t'((1 << MSI_BIT) | (1 << MTI_BIT) | (1 << MEI_BIT));

    // MXL = 1 (32 bit), extension I
    localparam xlen_t MISA_VALUE = 32'h4000_0100;

endpackage
